// ==== eth_rx.f ====
+incdir+logic
logic/eth_rx_pkg.sv
logic/axis_byte_if.sv
logic/frame_parser.sv
logic/rx_stream_fifo.sv
logic/rx_apb_regs.sv
logic/eth_rx_top.sv
test/eth_rx_tb.sv

// ==== logic/axis_byte_if.sv ====
interface axis_byte_if;

    logic [7:0] tdata;
    logic       tvalid;
    logic       tlast;
    logic       tready;

    modport master (
        output tdata,
        output tvalid,
        output tlast,
        input  tready
    );

    modport slave (
        input  tdata,
        input  tvalid,
        input  tlast,
        output tready
    );

endinterface

// ==== logic/eth_rx_consts.svh ====
`ifndef ETH_RX_CONSTS_SVH
`define ETH_RX_CONSTS_SVH

// ethernet header: dst mac, src mac, ethertype
`define ETH_HDR_BYTES 14

// seven 0x55 then the 0xd5 sfd, oldest byte in the low end
`define ETH_PREAMBLE_SFD 64'hd555_5555_5555_5555

`define RX_FIFO_DEPTH 16

`define REG_CTRL        8'h00
`define REG_MAC_LO      8'h04
`define REG_MAC_HI      8'h08
`define REG_FRAMES_OK   8'h0c
`define REG_FRAMES_DROP 8'h10
`define REG_STATUS      8'h14

`endif

// ==== logic/eth_rx_pkg.sv ====
`include "eth_rx_consts.svh"

package eth_rx_pkg;

    // fields in wire order, first byte on the wire is the msb
    typedef struct packed {
        logic [47:0] mac_dst;
        logic [47:0] mac_src;
        logic [15:0] ethertype;
    } eth_header_t;

    // bytes view is shifted in from the low end, fields view is decoded
    typedef union packed {
        eth_header_t                      fields;
        logic [`ETH_HDR_BYTES-1:0][7:0] bytes;
    } eth_header_u;

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        HEADER,
        PAYLOAD,
        DISCARD
    } parse_state_e;

endpackage

// ==== logic/eth_rx_top.sv ====
`include "eth_rx_consts.svh"

module eth_rx_top (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [7:0]  rx_d_i,
    input  logic        rx_dv_i,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [7:0]  paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,
    output logic [7:0]  m_tdata_o,
    output logic        m_tvalid_o,
    output logic        m_tlast_o,
    input  logic        m_tready_i
);

    logic [47:0] station_mac;
    logic        filter_en;
    logic        rx_en;
    logic        frame_ok;
    logic        frame_drop;
    logic        overflow;

    axis_byte_if rx_axis ();  // parser to fifo

    frame_parser u_parser (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .rx_d_i        (rx_d_i),
        .rx_dv_i       (rx_dv_i),
        .station_mac_i (station_mac),
        .filter_en_i   (filter_en),
        .rx_en_i       (rx_en),
        .frame_ok_o    (frame_ok),
        .frame_drop_o  (frame_drop),
        .m_axis        (rx_axis.master)
    );

    rx_stream_fifo #(
        .DEPTH (`RX_FIFO_DEPTH)
    ) u_fifo (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .s_axis     (rx_axis.slave),
        .m_tdata_o  (m_tdata_o),
        .m_tvalid_o (m_tvalid_o),
        .m_tlast_o  (m_tlast_o),
        .m_tready_i (m_tready_i),
        .overflow_o (overflow)
    );

    rx_apb_regs u_regs (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .paddr_i       (paddr_i),
        .pwdata_i      (pwdata_i),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),
        .frame_ok_i    (frame_ok),
        .frame_drop_i  (frame_drop),
        .overflow_i    (overflow),
        .station_mac_o (station_mac),
        .filter_en_o   (filter_en),
        .rx_en_o       (rx_en)
    );

endmodule

// ==== logic/frame_parser.sv ====
`include "eth_rx_consts.svh"

module frame_parser (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [7:0]  rx_d_i,
    input  logic        rx_dv_i,
    input  logic [47:0] station_mac_i,
    input  logic        filter_en_i,
    input  logic        rx_en_i,
    output logic        frame_ok_o,
    output logic        frame_drop_o,
    axis_byte_if.master m_axis
);
    import eth_rx_pkg::*;

    logic [2:0][7:0] rxd_z;
    logic [2:0]      rxdv_z;
    logic [7:0]      cur_d;
    logic            cur_dv;
    logic            frame_start;
    logic            last_byte;

    parse_state_e state;
    parse_state_e state_next;
    logic [3:0]   cnt;

    logic [63:0] pre_win;
    logic [63:0] pre_next;
    eth_header_u hdr;
    eth_header_u hdr_next;
    logic        hdr_done;
    logic        mac_hit;
    logic        is_bcast;
    logic        accept;

    logic [7:0] hold_d;
    logic       hold_v;
    logic [7:0] out_d;
    logic       out_v;
    logic       out_last;

    // input delay line
    always_ff @(posedge clk_i) begin
        rxd_z <= {rxd_z[1:0], rx_d_i};
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rxdv_z <= '0;
        end else begin
            rxdv_z <= {rxdv_z[1:0], rx_dv_i};
        end
    end

    assign cur_d       = rxd_z[2];
    assign cur_dv      = rxdv_z[2];
    assign frame_start = ~rxdv_z[2] & rxdv_z[1];  // first byte lands in stage 2 next cycle
    assign last_byte   = rxdv_z[2] & ~rxdv_z[1];

    assign pre_next       = {cur_d, pre_win[63:8]};
    assign hdr_next.bytes = {hdr.bytes[`ETH_HDR_BYTES-2:0], cur_d};

    // filter on the header as it will look once this byte is in
    assign mac_hit  = (hdr_next.fields.mac_dst == station_mac_i);
    assign is_bcast = &hdr_next.fields.mac_dst;
    assign accept   = rx_en_i & (~filter_en_i | mac_hit | is_bcast);
    assign hdr_done = (state == HEADER) && (cnt == 4'(`ETH_HDR_BYTES - 1));

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (frame_start) begin
                    state_next = PREAMBLE;
                end
            end
            PREAMBLE: begin
                if (last_byte) begin
                    state_next = IDLE;
                end else if (cnt == 4'd7) begin
                    state_next = (pre_next == `ETH_PREAMBLE_SFD) ? HEADER : DISCARD;
                end
            end
            HEADER: begin
                if (last_byte) begin
                    state_next = IDLE;  // runt gives no pulse unless the header just completed
                end else if (hdr_done) begin
                    state_next = accept ? PAYLOAD : DISCARD;
                end
            end
            PAYLOAD, DISCARD: begin
                if (last_byte) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            state <= state_next;
            if (state_next != state) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == PREAMBLE) begin
            pre_win <= pre_next;
        end
        if (state == HEADER) begin
            hdr <= hdr_next;
        end
        hold_d <= cur_d;
        out_d  <= hold_d;
    end

    // held byte is last when nothing follows it in stage 2
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hold_v       <= 1'b0;
            out_v        <= 1'b0;
            out_last     <= 1'b0;
            frame_drop_o <= 1'b0;
        end else begin
            hold_v       <= (state == PAYLOAD);
            out_v        <= hold_v;
            out_last     <= hold_v & ~cur_dv;
            frame_drop_o <= hdr_done & ~accept;
        end
    end

    assign frame_ok_o    = out_last;
    assign m_axis.tdata  = out_d;
    assign m_axis.tvalid = out_v;
    assign m_axis.tlast  = out_last;

    // the final beat of a frame is never followed directly by another beat
    last_has_valid: assert property (
        @(posedge clk_i) disable iff (rst_i)
        m_axis.tlast |-> m_axis.tvalid ##1 !m_axis.tvalid
    );

    ok_drop_exclusive: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(frame_ok_o && frame_drop_o)
    );

endmodule

// ==== logic/rx_apb_regs.sv ====
`include "eth_rx_consts.svh"

module rx_apb_regs (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [7:0]  paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,
    input  logic        frame_ok_i,
    input  logic        frame_drop_i,
    input  logic        overflow_i,
    output logic [47:0] station_mac_o,
    output logic        filter_en_o,
    output logic        rx_en_o
);

    logic        access;
    logic        addr_hit;
    logic        addr_ro;
    logic        wr_en;
    logic [31:0] frames_ok;
    logic [31:0] frames_drop;
    logic        ovf_sticky;

    assign access = psel_i & penable_i;
    assign wr_en  = access & pwrite_i & addr_hit & ~addr_ro;

    // read mux and decode
    always_comb begin
        addr_hit = 1'b1;
        addr_ro  = 1'b0;
        prdata_o = '0;
        case (paddr_i)
            `REG_CTRL:    prdata_o = {30'd0, filter_en_o, rx_en_o};
            `REG_MAC_LO:  prdata_o = station_mac_o[31:0];
            `REG_MAC_HI:  prdata_o = {16'd0, station_mac_o[47:32]};
            `REG_FRAMES_OK: begin
                prdata_o = frames_ok;
                addr_ro  = 1'b1;
            end
            `REG_FRAMES_DROP: begin
                prdata_o = frames_drop;
                addr_ro  = 1'b1;
            end
            `REG_STATUS:  prdata_o = {31'd0, ovf_sticky};
            default:      addr_hit = 1'b0;
        endcase
    end

    assign pready_o  = access;  // no wait states
    assign pslverr_o = access & (~addr_hit | (pwrite_i & addr_ro));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_en_o       <= 1'b0;
            filter_en_o   <= 1'b1;
            station_mac_o <= '0;
        end else if (wr_en) begin
            case (paddr_i)
                `REG_CTRL: begin
                    rx_en_o     <= pwdata_i[0];
                    filter_en_o <= pwdata_i[1];
                end
                `REG_MAC_LO: station_mac_o[31:0]  <= pwdata_i;
                `REG_MAC_HI: station_mac_o[47:32] <= pwdata_i[15:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            frames_ok   <= '0;
            frames_drop <= '0;
            ovf_sticky  <= 1'b0;
        end else begin
            if (frame_ok_i) begin
                frames_ok <= frames_ok + 1'b1;
            end
            if (frame_drop_i) begin
                frames_drop <= frames_drop + 1'b1;
            end
            // a new overflow wins over a clear in the same cycle
            if (overflow_i) begin
                ovf_sticky <= 1'b1;
            end else if (wr_en && paddr_i == `REG_STATUS && pwdata_i[0]) begin
                ovf_sticky <= 1'b0;
            end
        end
    end

    // error only in an access phase that followed its setup phase
    slverr_in_access: assert property (
        @(posedge clk_i) disable iff (rst_i)
        pslverr_o |-> psel_i && penable_i && $past(psel_i && !penable_i)
    );

endmodule

// ==== logic/rx_stream_fifo.sv ====
module rx_stream_fifo #(
    parameter int DEPTH = 16
) (
    input  logic        clk_i,
    input  logic        rst_i,
    axis_byte_if.slave  s_axis,
    output logic [7:0]  m_tdata_o,
    output logic        m_tvalid_o,
    output logic        m_tlast_o,
    input  logic        m_tready_i,
    output logic        overflow_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [AW-1:0] LAST_IDX = AW'(DEPTH - 1);
    localparam logic [AW:0]   FULL_CNT = (AW + 1)'(DEPTH);

    logic [8:0]    mem [DEPTH];  // {last, data}
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          wr_en;
    logic          rd_en;

    assign s_axis.tready = (count != FULL_CNT);
    assign wr_en         = s_axis.tvalid & s_axis.tready;
    assign rd_en         = m_tvalid_o & m_tready_i;

    // fall-through read of the head entry
    assign m_tvalid_o             = (count != '0);
    assign {m_tlast_o, m_tdata_o} = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_ptr] <= {s_axis.tlast, s_axis.tdata};
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            overflow_o <= s_axis.tvalid & ~s_axis.tready;  // beat lost
        end
    end

    // count stays in range and agrees with the pointer gap
    count_in_range: assert property (
        @(posedge clk_i) disable iff (rst_i)
        count <= FULL_CNT
        && (int'(wr_ptr) - int'(rd_ptr) + DEPTH) % DEPTH == int'(count) % DEPTH
    );

    data_held_on_stall: assert property (
        @(posedge clk_i) disable iff (rst_i)
        m_tvalid_o && !m_tready_i |=> m_tvalid_o && $stable(m_tdata_o)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the eth_rx testbench with verilator and runs it
# exit status comes from the search for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps \
    -f eth_rx.f --top-module eth_rx_tb \
    && ./obj_dir/Veth_rx_tb | grep "Finished with no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

exit 0

// ==== test/eth_rx_tb.sv ====
`include "eth_rx_consts.svh"

module eth_rx_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [47:0] STATION_MAC = 48'h11_22_33_44_55_66;
    localparam logic [47:0] OTHER_MAC   = 48'h02_aa_bb_cc_dd_ee;
    localparam logic [47:0] BCAST_MAC   = 48'hffff_ffff_ffff;
    localparam logic [47:0] SRC_MAC     = 48'h02_00_00_00_00_01;
    localparam logic [15:0] ETHERTYPE   = 16'h0800;
    localparam int IFG            = 12;
    localparam int FRAME_OVERHEAD = 8 + `ETH_HDR_BYTES + IFG + 1;
    localparam int PAYLOAD_SUM    = 205;  // all payload lengths sent below
    localparam int NUM_FRAMES     = 10;
    localparam int APB_CYCLES     = 26 * 3;
    localparam int TIMEOUT        = (3 * (PAYLOAD_SUM + NUM_FRAMES * FRAME_OVERHEAD)) / 2
                                    + APB_CYCLES + 200;

    logic        clk_i;
    logic        rst_i;
    logic [7:0]  rx_d_i;
    logic        rx_dv_i;
    logic        psel_i;
    logic        penable_i;
    logic        pwrite_i;
    logic [7:0]  paddr_i;
    logic [31:0] pwdata_i;
    logic [31:0] prdata_o;
    logic        pready_o;
    logic        pslverr_o;
    logic [7:0]  m_tdata_o;
    logic        m_tvalid_o;
    logic        m_tlast_o;
    logic        m_tready_i;

    // reference model state
    logic [8:0]  exp_q[$];  // {last, data}
    logic [8:0]  exp_head;
    int          exp_level;
    logic [47:0] model_mac;
    logic        model_rx_en;
    logic        model_filter_en;
    int          ok_cnt;
    int          drop_cnt;

    logic        apb_check;
    logic [31:0] rd_expect;
    logic        err_expect;
    logic [31:0] data_lfsr;
    logic [31:0] ready_lfsr;
    logic [31:0] ready_bits;
    logic [1:0]  ready_mode;  // 0 always ready, 1 random, 2 stalled
    logic [1:0]  mode_now;
    int          cycle_cnt;
    string       test_name;

    eth_rx_top uut (.*);

    always #50 clk_i = ~clk_i;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
        end
        return s >> 1;
    endfunction

    task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], st[0]};
            st  = lfsr_step(st);
        end
    endtask

    task automatic fail_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped on a failed check");
    endtask

    task automatic refresh_head();
        exp_level = exp_q.size();
        exp_head  = (exp_level > 0) ? exp_q[0] : 9'h000;
    endtask

    task automatic bus_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              input logic [31:0] rexp, input logic eexp);
        @(posedge clk_i);
        #10;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(posedge clk_i);
        #10;
        penable_i  = 1'b1;  // access phase
        apb_check  = 1'b1;
        rd_expect  = rexp;
        err_expect = eexp;
        @(posedge clk_i);
        #10;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        apb_check = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic err);
        bus_access(1'b1, addr, data, 32'h0, err);
    endtask

    task automatic read_reg(input logic [7:0] addr, input logic [31:0] exp, input logic err);
        bus_access(1'b0, addr, 32'h0, exp, err);
    endtask

    task automatic set_ctrl(input logic rx_en, input logic filter_en);
        write_reg(`REG_CTRL, {30'd0, filter_en, rx_en}, 1'b0);
        model_rx_en     = rx_en;
        model_filter_en = filter_en;
    endtask

    task automatic drive_byte(input logic [7:0] b);
        @(posedge clk_i);
        #10;
        rx_d_i  = b;
        rx_dv_i = 1'b1;
    endtask

    // keep limits how many payload bytes the fifo is expected to hold on to
    task automatic send_frame(input logic [47:0] dst, input int len, input int keep,
                              input logic bad_sfd);
        logic [111:0] hdr;
        logic [31:0]  r;
        logic [7:0]   b;
        logic         acc;
        hdr = {dst, SRC_MAC, ETHERTYPE};
        acc = model_rx_en && (!model_filter_en || dst == model_mac || dst == BCAST_MAC);
        for (int i = 0; i < 7; i++) begin
            drive_byte(8'h55);
        end
        drive_byte(bad_sfd ? 8'hd4 : 8'hd5);
        for (int i = 0; i < `ETH_HDR_BYTES; i++) begin
            drive_byte(hdr[111 - 8 * i -: 8]);
        end
        for (int i = 0; i < len; i++) begin
            take_bits(data_lfsr, 8, r);
            b = r[7:0];
            drive_byte(b);
            if (acc && !bad_sfd && i < keep) begin
                exp_q.push_back({(i == len - 1), b});
                refresh_head();
            end
        end
        @(posedge clk_i);
        #10;
        rx_dv_i = 1'b0;
        rx_d_i  = 8'h00;
        repeat (IFG) @(posedge clk_i);
        if (!bad_sfd) begin
            if (acc) ok_cnt++;
            else drop_cnt++;
        end
    endtask

    task automatic wait_drained();
        do begin
            @(posedge clk_i);
            #10;
        end while (exp_level != 0 || m_tvalid_o);
    endtask

    // output sink
    always @(posedge clk_i) begin
        if (!rst_i && m_tvalid_o && m_tready_i) begin
            if (exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
            refresh_head();
        end
    end

    always @(posedge clk_i) begin
        mode_now = ready_mode;
        #10;
        case (mode_now)
            2'd1: begin
                take_bits(ready_lfsr, 2, ready_bits);
                m_tready_i = |ready_bits[1:0];  // ready three cycles in four
            end
            2'd2:    m_tready_i = 1'b0;
            default: m_tready_i = 1'b1;
        endcase
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT);
            fail_run();
        end
    end

    out_expected: assert property (@(posedge clk_i) disable iff (rst_i)
        m_tvalid_o && m_tready_i |-> exp_level > 0)
    else begin
        $display("%s: an output beat arrived while no byte was expected", test_name);
        fail_run();
    end

    out_match: assert property (@(posedge clk_i) disable iff (rst_i)
        m_tvalid_o && m_tready_i && exp_level > 0 |-> {m_tlast_o, m_tdata_o} == exp_head)
    else begin
        $display("ERR %s: expected %h, actual %h", test_name, $sampled(exp_head),
                 $sampled({m_tlast_o, m_tdata_o}));
        fail_run();
    end

    hold_on_stall: assert property (@(posedge clk_i) disable iff (rst_i)
        m_tvalid_o && !m_tready_i |=> m_tvalid_o && $stable(m_tdata_o))
    else begin
        $display("%s: output data changed while the sink stalled", test_name);
        fail_run();
    end

    ready_in_access: assert property (@(posedge clk_i) disable iff (rst_i)
        apb_check |-> pready_o)
    else begin
        $display("%s: pready was low in an APB access phase", test_name);
        fail_run();
    end

    slverr_match: assert property (@(posedge clk_i) disable iff (rst_i)
        apb_check |-> pslverr_o == err_expect)
    else begin
        $display("ERR %s: expected pslverr %0b, actual %0b", test_name, $sampled(err_expect),
                 $sampled(pslverr_o));
        fail_run();
    end

    rdata_match: assert property (@(posedge clk_i) disable iff (rst_i)
        apb_check && !pwrite_i |-> prdata_o == rd_expect)
    else begin
        $display("ERR %s: expected %h, actual %h", test_name, $sampled(rd_expect),
                 $sampled(prdata_o));
        fail_run();
    end

    initial begin
        clk_i = 1'b0;
        rst_i = 1'b1;
        rx_d_i = 8'h00;
        rx_dv_i = 1'b0;
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        paddr_i = 8'h00;
        pwdata_i = 32'h0;
        m_tready_i = 1'b1;
        ready_mode = 2'd0;
        apb_check = 1'b0;
        rd_expect = 32'h0;
        err_expect = 1'b0;
        data_lfsr = 32'h784d23a6;
        ready_lfsr = 32'h784d23a6;
        cycle_cnt = 0;
        ok_cnt = 0;
        drop_cnt = 0;
        model_mac = 48'h0;
        model_rx_en = 1'b0;
        model_filter_en = 1'b1;
        refresh_head();
        test_name = "apb";
        repeat (3) @(posedge clk_i);
        #10;
        rst_i = 1'b0;

        read_reg(`REG_CTRL, 32'h2, 1'b0);  // filter on, receive off
        read_reg(`REG_FRAMES_OK, 32'h0, 1'b0);
        read_reg(`REG_FRAMES_DROP, 32'h0, 1'b0);
        read_reg(`REG_STATUS, 32'h0, 1'b0);
        write_reg(`REG_MAC_LO, STATION_MAC[31:0], 1'b0);
        write_reg(`REG_MAC_HI, {16'h0, STATION_MAC[47:32]}, 1'b0);
        model_mac = STATION_MAC;
        set_ctrl(1'b1, 1'b1);
        read_reg(`REG_MAC_LO, STATION_MAC[31:0], 1'b0);
        read_reg(`REG_MAC_HI, {16'h0, STATION_MAC[47:32]}, 1'b0);
        read_reg(`REG_CTRL, 32'h3, 1'b0);
        read_reg(8'h20, 32'h0, 1'b1);
        write_reg(`REG_FRAMES_OK, 32'h5, 1'b1);  // read-only

        test_name = "unicast";
        send_frame(STATION_MAC, 32, 32, 1'b0);
        wait_drained();
        read_reg(`REG_FRAMES_OK, ok_cnt, 1'b0);

        test_name = "filter";
        send_frame(OTHER_MAC, 16, 16, 1'b0);
        wait_drained();
        read_reg(`REG_FRAMES_DROP, drop_cnt, 1'b0);
        send_frame(BCAST_MAC, 20, 20, 1'b0);
        set_ctrl(1'b1, 1'b0);
        send_frame(OTHER_MAC, 12, 12, 1'b0);
        set_ctrl(1'b0, 1'b0);
        send_frame(STATION_MAC, 10, 10, 1'b0);
        wait_drained();
        read_reg(`REG_FRAMES_OK, ok_cnt, 1'b0);
        read_reg(`REG_FRAMES_DROP, drop_cnt, 1'b0);
        set_ctrl(1'b1, 1'b1);

        test_name = "backpressure";
        ready_mode = 2'd1;
        send_frame(STATION_MAC, 20, 20, 1'b0);
        send_frame(BCAST_MAC, 30, 30, 1'b0);
        send_frame(STATION_MAC, 25, 25, 1'b0);
        wait_drained();
        ready_mode = 2'd0;
        read_reg(`REG_FRAMES_OK, ok_cnt, 1'b0);

        test_name = "overflow";
        ready_mode = 2'd2;
        send_frame(STATION_MAC, 24, `RX_FIFO_DEPTH, 1'b0);
        read_reg(`REG_STATUS, 32'h1, 1'b0);
        write_reg(`REG_STATUS, 32'h1, 1'b0);
        read_reg(`REG_STATUS, 32'h0, 1'b0);
        ready_mode = 2'd0;
        wait_drained();
        read_reg(`REG_FRAMES_OK, ok_cnt, 1'b0);

        test_name = "bad_preamble";
        send_frame(STATION_MAC, 16, 16, 1'b1);
        wait_drained();
        read_reg(`REG_FRAMES_OK, ok_cnt, 1'b0);
        read_reg(`REG_FRAMES_DROP, drop_cnt, 1'b0);

        $display("Finished with no errors");
        $finish;
    end

endmodule
